//--- design/core_cfg_pkg.sv
package core_cfg_pkg;

    // datapath sizing.
    localparam int data_width_c = 32;
    localparam int reg_count_c = 8;

    // three-bit register index for eight entries.
    typedef logic [2:0] reg_idx_t;

    // program counter.
    typedef logic [15:0] pc_t;

    // sequencer steps of one cycle each.
    typedef enum logic [1:0]
    {
        st_idle  = 2'd0,
        st_read  = 2'd1,
        st_exec  = 2'd2,
        st_write = 2'd3
    } seq_state_t;

endpackage

//--- design/core_isa_pkg.sv
package core_isa_pkg;

    import core_cfg_pkg::*;

    typedef enum logic [3:0]
    {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_shl  = 4'd2,   // ones shifted in.
        op_shr  = 4'd3,   // ones shifted in.
        op_mov  = 4'd4,
        op_ldl  = 4'd5,
        op_ldh  = 4'd6,
        op_ceq  = 4'd8,
        op_clt  = 4'd9,
        op_cgt  = 4'd10,
        op_cnot = 4'd11,
        op_jmp  = 4'd14,
        op_bf   = 4'd15
    } opcode_t;

    typedef logic [15:0] imm_t;
    typedef logic [2:0] spare_t;

    // opcode in the top nibble, immediate in the low half.
    typedef struct packed
    {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t ra;
        reg_idx_t rb;
        spare_t   spare;
        imm_t     imm;
    } instr_t;

    function automatic logic is_compare(input opcode_t op);
        return (op == op_ceq) || (op == op_clt) || (op == op_cgt) || (op == op_cnot);
    endfunction

    function automatic logic is_branch(input opcode_t op);
        return (op == op_jmp) || (op == op_bf);
    endfunction

endpackage

//--- design/exec_bus_if.sv
interface exec_bus_if
    import core_isa_pkg::*;
    import core_cfg_pkg::*;
#(
    parameter int data_width = data_width_c
)
();

    opcode_t               op;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    imm_t                  imm;
    logic                  go;   // one-cycle exec strobe.

    modport source
    (
        output op,
        output a,
        output b,
        output imm,
        output go
    );

    modport sink
    (
        input op,
        input a,
        input b,
        input imm,
        input go
    );

endinterface

//--- design/seq_fsm.sv
module seq_fsm
    import core_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       instr_strobe,
    input  instr_t     instr,
    output seq_state_t state,
    output instr_t     cur,
    output logic       rd_en,
    output logic       go,
    output logic       wb_strobe,
    output logic       wb_write
);

    seq_state_t state_next;

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
            begin
                if (instr_strobe)
                begin
                    state_next = st_read;
                end
            end
            st_read:
            begin
                state_next = st_exec;
            end
            st_exec:
            begin
                state_next = st_write;
            end
            st_write:
            begin
                state_next = st_idle;
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    // strobes while busy never reach here.
    always_ff @(posedge clock)
    begin
        if (state == st_idle && instr_strobe)
        begin
            cur <= instr;
        end
    end

    assign rd_en = (state == st_read);
    assign go = (state == st_exec);
    assign wb_strobe = (state == st_write);

    // compares and branches leave the registers alone.
    assign wb_write = wb_strobe && !is_compare(cur.opcode) && !is_branch(cur.opcode);

endmodule

//--- design/pc_counter.sv
module pc_counter
    import core_cfg_pkg::*;
(
    input  logic clock,
    input  logic rst,
    input  logic step,
    input  logic load,
    input  pc_t  target,
    output pc_t  pc
);

    pc_t pc_next;

    always_comb
    begin
        if (load)
        begin
            pc_next = target;   // jump taken.
        end
        else
        begin
            pc_next = pc + pc_t'(1);
        end
    end

    // moves once per instruction at write-back.
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            pc <= '0;
        end
        else if (step)
        begin
            pc <= pc_next;
        end
    end

endmodule

//--- design/reg_file.sv
module reg_file
    import core_cfg_pkg::*;
#(
    parameter int data_width = data_width_c,
    parameter int reg_count = reg_count_c
)
(
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  rd_en,
    input  reg_idx_t              ra,
    input  reg_idx_t              rb,
    output logic [data_width-1:0] a,
    output logic [data_width-1:0] b,
    input  logic                  we,
    input  reg_idx_t              wa,
    input  logic [data_width-1:0] wd
);

    logic [data_width-1:0] regs [reg_count];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < reg_count; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we)
        begin
            regs[wa] <= wd;
        end
    end

    // operands held until the next read step.
    always_ff @(posedge clock)
    begin
        if (rd_en)
        begin
            a <= regs[ra];
            b <= regs[rb];
        end
    end

endmodule

//--- design/alu.sv
module alu
    import core_isa_pkg::*;
    import core_cfg_pkg::*;
#(
    parameter int data_width = data_width_c
)
(
    input  logic                  clock,
    input  logic                  rst,
    exec_bus_if.sink              bus,
    output logic [data_width-1:0] result,
    output logic                  flag
);

    localparam int sh_w = $clog2(data_width);

    logic [sh_w-1:0]       shamt;
    logic [data_width-1:0] res_next;
    logic                  flag_next;

    assign shamt = bus.b[sh_w-1:0];

    always_comb
    begin
        res_next = '0;
        case (bus.op)
            op_add:
            begin
                res_next = bus.a + bus.b;
            end
            op_sub:
            begin
                res_next = bus.a - bus.b;
            end
            op_shl:
            begin
                res_next = ~((~bus.a) << shamt);   // ones fill the low end.
            end
            op_shr:
            begin
                res_next = ~((~bus.a) >> shamt);
            end
            op_mov:
            begin
                res_next = bus.a;
            end
            op_ldl:
            begin
                res_next = bus.a;
                res_next[15:0] = bus.imm;
            end
            op_ldh:
            begin
                res_next = bus.a;
                res_next[data_width-1 -: 16] = bus.imm;
            end
            default:
            begin
                res_next = '0;   // compares and branches.
            end
        endcase
    end

    always_comb
    begin
        flag_next = flag;
        case (bus.op)
            op_ceq:
            begin
                flag_next = (bus.a == bus.b);
            end
            op_clt:
            begin
                flag_next = (bus.a < bus.b);
            end
            op_cgt:
            begin
                flag_next = (bus.a > bus.b);
            end
            op_cnot:
            begin
                flag_next = ~flag;
            end
            default:
            begin
                flag_next = flag;
            end
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (bus.go)
        begin
            result <= res_next;
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            flag <= 1'b0;
        end
        else if (bus.go)
        begin
            flag <= flag_next;
        end
    end

endmodule

//--- design/alu_core.sv
module alu_core
    import core_isa_pkg::*;
    import core_cfg_pkg::*;
#(
    parameter int data_width = data_width_c,
    parameter int reg_count = reg_count_c
)
(
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  instr_strobe,
    input  logic [31:0]           instr,
    output logic                  busy,
    output logic                  wb_strobe,
    output reg_idx_t              wb_reg,
    output logic [data_width-1:0] wb_data,
    output logic                  wb_write,
    output logic                  flag,
    output pc_t                   pc
);

    seq_state_t state;
    instr_t     cur;
    logic       rd_en;
    logic       jump;

    exec_bus_if #(.data_width(data_width)) bus ();

    seq_fsm i_seq
    (
        .clock        (clock),
        .rst          (rst),
        .instr_strobe (instr_strobe),
        .instr        (instr_t'(instr)),
        .state        (state),
        .cur          (cur),
        .rd_en        (rd_en),
        .go           (bus.go),
        .wb_strobe    (wb_strobe),
        .wb_write     (wb_write)
    );

    reg_file #(.data_width(data_width), .reg_count(reg_count)) i_regs
    (
        .clock (clock),
        .rst   (rst),
        .rd_en (rd_en),
        .ra    (cur.ra),
        .rb    (cur.rb),
        .a     (bus.a),
        .b     (bus.b),
        .we    (wb_write),
        .wa    (cur.rd),
        .wd    (wb_data)
    );

    assign bus.op = cur.opcode;
    assign bus.imm = cur.imm;

    alu #(.data_width(data_width)) i_alu
    (
        .clock  (clock),
        .rst    (rst),
        .bus    (bus.sink),
        .result (wb_data),
        .flag   (flag)
    );

    // flag is still the pre-branch value at write-back.
    assign jump = (cur.opcode == op_jmp) || (cur.opcode == op_bf && flag);

    pc_counter i_pc
    (
        .clock  (clock),
        .rst    (rst),
        .step   (wb_strobe),
        .load   (jump),
        .target (bus.b[$bits(pc_t)-1:0]),
        .pc     (pc)
    );

    assign busy = (state != st_idle);
    assign wb_reg = cur.rd;

endmodule

//--- verification/alu_core_tb.sv
module alu_core_tb
    import core_isa_pkg::*;
    import core_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clock_period = 100;
    localparam int reset_cycles = 16;
    localparam int rand_count = 64;

    logic                    clock;
    logic                    rst;
    logic                    instr_strobe;
    logic [31:0]             instr;
    logic                    busy;
    logic                    wb_strobe;
    reg_idx_t                wb_reg;
    logic [data_width_c-1:0] wb_data;
    logic                    wb_write;
    logic                    flag;
    pc_t                     pc;

    string                   names [$];
    logic [31:0]             words [$];
    logic [data_width_c-1:0] datas [$];
    logic                    flags [$];
    pc_t                     pcs [$];
    logic [data_width_c-1:0] model [reg_count_c];   // expected register contents.
    int                      wb_count;
    logic                    loaded;
    int                      seed = 28854;

    alu_core #(.data_width(data_width_c), .reg_count(reg_count_c)) i_dut
    (
        .clock        (clock),
        .rst          (rst),
        .instr_strobe (instr_strobe),
        .instr        (instr),
        .busy         (busy),
        .wb_strobe    (wb_strobe),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .wb_write     (wb_write),
        .flag         (flag),
        .pc           (pc)
    );

    initial
    begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    always @(posedge clock)
    begin
        if (rst)
        begin
            wb_count <= 0;
        end
        else if (wb_strobe)
        begin
            wb_count <= wb_count + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_data(input string name, input logic [data_width_c-1:0] expected,
                              input logic [data_width_c-1:0] actual);
        if (actual !== expected)
        begin
            $display("** Error: %s wb_data expected %h actual %h", name, expected, actual);
            abort_run("wb_data mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("** Error: %s expected %b actual %b", name, expected, actual);
            abort_run("single-bit output mismatch");
        end
    endtask

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        if (actual !== expected)
        begin
            $display("** Error: %s pc expected %h actual %h", name, expected, actual);
            abort_run("pc mismatch");
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t expected,
                             input reg_idx_t actual);
        if (actual !== expected)
        begin
            $display("** Error: %s wb_reg expected %0d actual %0d", name, expected, actual);
            abort_run("wb_reg mismatch");
        end
    endtask

    // only the data opcodes write a register.
    function automatic logic writes_reg(input opcode_t op);
        case (op)
            op_add, op_sub, op_shl, op_shr, op_mov, op_ldl, op_ldh:
            begin
                return 1'b1;
            end
            default:
            begin
                return 1'b0;
            end
        endcase
    endfunction

    task automatic load_patterns();
        int                      fd;
        int                      n;
        string                   line;
        string                   name;
        logic [31:0]             word;
        logic [data_width_c-1:0] data;
        logic                    flg;
        pc_t                     pcv;
        fd = $fopen("verification/alu_core_patterns.txt", "r");
        if (fd == 0)
        begin
            abort_run("could not open verification/alu_core_patterns.txt");
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%s %h %h %b %h", name, word, data, flg, pcv) == 5)
            begin
                names.push_back(name);   // comment lines fail the scan.
                words.push_back(word);
                datas.push_back(data);
                flags.push_back(flg);
                pcs.push_back(pcv);
            end
        end
        $fclose(fd);
    endtask

    // strobe at cycle 0, a second strobe while busy, write-back at cycle 3.
    task automatic issue_instr(input string name, input logic [31:0] word,
                               input logic [data_width_c-1:0] exp_data, input logic exp_flag,
                               input pc_t exp_pc);
        instr_t ins;
        logic   exp_write;
        ins = instr_t'(word);
        exp_write = writes_reg(ins.opcode);
        instr = word;
        instr_strobe = 1'b1;
        @(posedge clock);
        #5;
        instr_strobe = 1'b0;
        check_flag({name, " busy"}, 1'b1, busy);
        @(posedge clock);
        #5;
        check_flag({name, " early wb_strobe"}, 1'b0, wb_strobe);
        instr = 32'h5e00_dead;   // ldl r7 that must be dropped.
        instr_strobe = 1'b1;
        @(posedge clock);
        #5;
        instr_strobe = 1'b0;
        check_flag({name, " wb_strobe"}, 1'b1, wb_strobe);
        check_flag({name, " wb_write"}, exp_write, wb_write);
        check_reg(name, ins.rd, wb_reg);
        check_data(name, exp_data, wb_data);
        check_flag({name, " flag"}, exp_flag, flag);
        @(posedge clock);
        #5;
        check_flag({name, " busy after write-back"}, 1'b0, busy);
        check_pc(name, exp_pc, pc);
        if (exp_write)
        begin
            model[ins.rd] = exp_data;
        end
    endtask

    initial
    begin
        wait (loaded);
        #((names.size() + rand_count) * 5 * clock_period + reset_cycles * clock_period);
        abort_run("simulation timed out before all instructions were written back");
    end

    initial
    begin
        opcode_t                 op;
        logic [31:0]             r;
        logic [data_width_c-1:0] expected;
        pc_t                     exp_pc;
        logic                    exp_flag;
        rst = 1'b1;
        instr_strobe = 1'b0;
        instr = '0;
        loaded = 1'b0;
        for (int i = 0; i < reg_count_c; i++)
        begin
            model[i] = '0;
        end
        load_patterns();
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #5;
        rst = 1'b0;
        @(posedge clock);
        #5;
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset wb_strobe", 1'b0, wb_strobe);
        check_flag("reset wb_write", 1'b0, wb_write);
        check_flag("reset flag", 1'b0, flag);
        check_pc("reset", 16'h0000, pc);
        for (int i = 0; i < names.size(); i++)
        begin
            issue_instr(names[i], words[i], datas[i], flags[i], pcs[i]);
        end
        exp_pc = pcs[pcs.size() - 1];
        exp_flag = flags[flags.size() - 1];
        for (int i = 0; i < rand_count; i++)
        begin
            r = $random(seed);
            op = r[0] ? op_sub : op_add;
            expected = (op == op_add) ? model[r[6:4]] + model[r[9:7]]
                                      : model[r[6:4]] - model[r[9:7]];
            exp_pc = exp_pc + 16'h0001;
            issue_instr($sformatf("rand_%0d", i), {op, r[3:1], r[6:4], r[9:7], 3'b000, r[31:16]},
                        expected, exp_flag, exp_pc);
        end
        if (wb_count != names.size() + rand_count)
        begin
            $display("expected %0d write-back strobes but saw %0d", names.size() + rand_count,
                     wb_count);
            abort_run("write-back strobe count is wrong");
        end
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- alu_core.f
design/core_cfg_pkg.sv
design/core_isa_pkg.sv
design/exec_bus_if.sv
design/seq_fsm.sv
design/pc_counter.sv
design/reg_file.sv
design/alu.sv
design/alu_core.sv
verification/alu_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timescale 1ns/1ps --top-module alu_core_tb -f alu_core.f \
    -o alu_core_sim && ./obj_dir/alu_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "^Test passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verification/alu_core_patterns.txt
# test_name  instr  wb_data  flag  pc   (all hex except flag)
# one instruction per line, applied in order after reset
ldl_r1            52005678  00005678  0  0001
ldh_r1            62401234  12345678  0  0002
ldl_r2            5400ffff  0000ffff  0  0003
ldh_r2            6480ffff  ffffffff  0  0004
ldh_r3            66008000  80000000  0  0005
ldl_r3_keep_high  56c00001  80000001  0  0006
mov_r4_r1         48400000  12345678  0  0007
mov_r5_r3         4ac00000  80000001  0  0008
add_r6            0c600000  2468acf0  0  0009
add_wrap          0e900000  fffffffe  0  000a
add_carry_out     0ee80000  00000002  0  000b
sub_equal         1c600000  00000000  0  000c
sub_wrap          1c080000  edcba988  0  000d
sub_r7            1eb80000  fffffffd  0  000e
ldl_shift4        5a000004  00000004  0  000f
shl_ones          2c680000  2345678f  0  0010
shr_ones          3c680000  f1234567  0  0011
shr_by_one        3ed80000  c0000000  0  0012
shl_by_zero       2e400000  12345678  0  0013
ldl_shift31       5a00003f  0000003f  0  0014
shl_by_31         2d280000  7fffffff  0  0015
ceq_true          80600000  00000000  1  0016
ceq_false         80500000  00000000  0  0017
clt_true          90500000  00000000  1  0018
clt_false         90880000  00000000  0  0019
clt_equal         90600000  00000000  0  001a
cgt_true          a0c80000  00000000  1  001b
cgt_false         a0580000  00000000  0  001c
cnot_set          b0000000  00000000  1  001d
cnot_clear        b0000000  00000000  0  001e
ldl_target        5a000100  00000100  0  001f
jmp_r5            e0280000  00000000  0  0100
bf_not_taken      f0280000  00000000  0  0101
cnot_before_bf    b0000000  00000000  1  0102
ldl_r6_target     5c000240  00000240  1  0103
bf_taken          f0300000  00000000  1  0240
jmp_high_bits     e0080000  00000000  1  5678
add_after_jump    0f700000  00000340  1  5679
ceq_clear         81700000  00000000  0  567a
